//--- project.f
hdl/muldiv_pkg.sv
hdl/muldiv_fsm.sv
hdl/muldiv_exec_cnt.sv
hdl/booth_mul_dpath.sv
hdl/nrdiv_dpath.sv
hdl/muldiv_share_dpath.sv
hdl/muldiv_result_sel.sv
hdl/muldiv_top.sv
verification/muldiv_tb.sv

//--- verification/muldiv_tb.sv
/*
  Multiply/divide unit testbench
*/
module muldiv_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import muldiv_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 2;
  localparam int SAMPLE_DLY  = 18;
  localparam int MAX_LAT     = 36;
  localparam int NUM_CORNERS = 7;
  localparam int NUM_RAND    = 200;
  localparam int NUM_BP      = 16;
  // Mul and div sweeps, specials, back-pressure and reset ops
  localparam int NUM_OPS     = 2 * 4 * (NUM_CORNERS * NUM_CORNERS + NUM_RAND) + NUM_BP + 16;
  localparam int WATCHDOG_NS = (NUM_OPS * 40 + 200) * CLK_PERIOD;

  logic        clk;
  logic        i_reset;
  logic        i_valid;
  muldiv_req_t i_req;
  logic        i_ready_out;
  logic        o_ready;
  logic        o_valid;
  xlen_t       o_result;

  xlen_t lcg_state;
  int    err_cnt;

  muldiv_top u_dut (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_req       (i_req),
    .i_ready_out (i_ready_out),
    .o_ready     (o_ready),
    .o_valid     (o_valid),
    .o_result    (o_result)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Helpers

  function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Signed corners plus two small odd values
  function automatic xlen_t corner_val(input int idx);
    case (idx)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h7fff_ffff;
      5: return 32'h0000_0003;
      default: return 32'hffff_fff9;
    endcase
  endfunction

  // Divide by zero or most negative over -1
  function automatic logic is_special(input muldiv_op_e op, input xlen_t a, input xlen_t b);
    return op[2] && ((b == '0) || (((op == OP_DIV) || (op == OP_REM))
                                   && (a == 32'h8000_0000) && (b == '1)));
  endfunction

  // RISC-V M extension rules
  function automatic xlen_t ref_result(input muldiv_op_e op, input xlen_t a, input xlen_t b);
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               ovf;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == '1);
    ea  = {32'h0, a};
    eb  = {32'h0, b};
    // Sign extension by operand signedness
    if (op == OP_MUL || op == OP_MULH || op == OP_MULHSU) begin
      ea = {{32{a[31]}}, a};
    end
    if (op == OP_MUL || op == OP_MULH) begin
      eb = {{32{b[31]}}, b};
    end
    prod = ea * eb;
    case (op)
      OP_MUL:  return prod[31:0];
      OP_MULH, OP_MULHSU, OP_MULHU: return prod[63:32];
      OP_DIV:  return (b == '0) ? '1 : ovf ? 32'h8000_0000 : xlen_t'(sa / sb);
      OP_DIVU: return (b == '0) ? '1 : a / b;
      OP_REM:  return (b == '0) ? a : ovf ? '0 : xlen_t'(sa % sb);
      default: return (b == '0) ? a : a % b;
    endcase
  endfunction

  task automatic report_failure(input string what);
    err_cnt++;
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping on the first failure");
  endtask

  task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopping on a mismatch");
    end
  endtask

  // Starts and ends at the drive point after a rising edge
  // Stall is the number of extra cycles with the sink not ready
  task automatic run_op(input muldiv_op_e op, input xlen_t a, input xlen_t b, input int stall);
    xlen_t exp;
    xlen_t held;
    int    cyc;
    exp         = ref_result(op, a, b);
    i_req       = '{op: op, rs1: a, rs2: b};
    i_valid     = 1'b1;
    i_ready_out = (stall == 0);
    cyc         = 1;
    #(SAMPLE_DLY);
    while (!o_valid && cyc < MAX_LAT) begin
      @(posedge clk);
      #(DRIVE_DLY);
      cyc++;
      #(SAMPLE_DLY);
    end
    if (!o_valid) begin
      report_failure($sformatf("%s never raised o_valid within %0d cycles", op.name(), MAX_LAT));
    end
    // Issue cycle counts as cycle 1
    if (is_special(op, a, b)) begin
      check_value("special_latency", cyc, 1);
    end else if (!op[2]) begin
      check_value("mul_latency", cyc, 17);
    end else if (cyc != 34 && cyc != 36) begin
      report_failure($sformatf("%s finished after %0d cycles, not 34 or 36", op.name(), cyc));
    end
    // Signed remainder follows the dividend sign
    if (op == OP_REM && o_result != '0 && b != '0) begin
      check_value("rem_sign", o_result[31], a[31]);
    end
    check_value("o_result", o_result, exp);
    held = o_result;
    if (stall > 0) begin
      check_value("o_ready", o_ready, 1'b0);
      repeat (stall) begin
        @(posedge clk);
        #(DRIVE_DLY + SAMPLE_DLY);
        check_value("o_valid", o_valid, 1'b1);
        check_value("o_ready", o_ready, 1'b0);
        check_value("o_result", o_result, held);
      end
      @(posedge clk);
      #(DRIVE_DLY);
      i_ready_out = 1'b1;
      #(SAMPLE_DLY);
      check_value("o_valid", o_valid, 1'b1);
      check_value("o_result", o_result, exp);
    end
    check_value("o_ready", o_ready, 1'b1);
    // Handshake completes at this edge
    @(posedge clk);
    #(DRIVE_DLY);
    i_valid = 1'b0;
    i_req   = '0;
  endtask

  ////////////////////
  // Tests

  task automatic test_reset();
    #(SAMPLE_DLY);
    check_value("o_valid", o_valid, 1'b0);
    check_value("o_ready", o_ready, 1'b0);
    @(posedge clk);
    #(DRIVE_DLY);
    run_op(OP_MUL, 32'h1234_5678, 32'h9abc_def0, 0);
    run_op(OP_DIV, 32'hdead_beef, 32'h0000_1234, 0);
  endtask

  task automatic test_mul();
    muldiv_op_e op;
    for (int k = 0; k < 4; k++) begin
      op = muldiv_op_e'(k);
      for (int i = 0; i < NUM_CORNERS; i++) begin
        for (int j = 0; j < NUM_CORNERS; j++) begin
          run_op(op, corner_val(i), corner_val(j), 0);
        end
      end
      repeat (NUM_RAND) begin
        run_op(op, lcg_next(), lcg_next(), 0);
      end
    end
  endtask

  task automatic test_div();
    muldiv_op_e op;
    xlen_t      a;
    xlen_t      b;
    xlen_t      r;
    for (int k = 4; k < 8; k++) begin
      op = muldiv_op_e'(k);
      for (int i = 0; i < NUM_CORNERS; i++) begin
        for (int j = 0; j < NUM_CORNERS; j++) begin
          run_op(op, corner_val(i), corner_val(j), 0);
        end
      end
      repeat (NUM_RAND) begin
        a = lcg_next();
        b = lcg_next();
        r = lcg_next();
        // Shrink half the divisors for varied quotient sizes
        if (r[5]) begin
          b = $signed(b) >>> r[4:0];
        end
        run_op(op, a, b, 0);
      end
    end
  endtask

  task automatic test_special();
    run_op(OP_DIV, 32'h0000_0042, 32'h0, 0);
    run_op(OP_DIVU, 32'h8000_0000, 32'h0, 0);
    run_op(OP_REM, 32'hffff_ff00, 32'h0, 0);
    run_op(OP_REMU, 32'h1357_9bdf, 32'h0, 0);
    run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
    run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff, 0);
    // Unsigned form is a normal divide
    run_op(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 0);
  endtask

  task automatic test_backpressure();
    xlen_t r;
    run_op(OP_DIV, 32'h0000_0042, 32'h0, 3);
    repeat (NUM_BP) begin
      r = lcg_next();
      run_op(muldiv_op_e'(r[2:0]), lcg_next(), lcg_next(), int'(r[5:3]) + 1);
    end
    // Next issue after a stalled one
    run_op(OP_REM, 32'hffff_fff9, 32'h0000_0003, 0);
  endtask

  ////////////////////
  // Main

  initial begin
    clk         = 1'b0;
    i_reset     = 1'b1;
    i_valid     = 1'b0;
    i_req       = '0;
    i_ready_out = 1'b1;
    lcg_state   = 32'h8f59;
    err_cnt     = 0;
    repeat (8) @(posedge clk);
    #(DRIVE_DLY);
    i_reset = 1'b0;
    test_reset();
    test_mul();
    test_div();
    test_special();
    test_backpressure();
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Hang guard sized from the op count
  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- hdl/muldiv_top.sv
/*
  Iterative multiply/divide unit
*/
module muldiv_top (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  input  logic                    i_ready_out,
  output logic                    o_ready,
  output logic                    o_valid,
  output muldiv_pkg::xlen_t       o_result
);
  import muldiv_pkg::*;

  muldiv_state_e state;
  logic          is_div;
  logic          exec_enter;
  logic          exec_last;
  logic          wbck;
  logic          need_corr;
  logic          special;
  adder_req_t    mul_req;
  adder_req_t    div_req;
  part_t         mul_hi_nxt;
  part_t         mul_lo_nxt;
  logic          mul_sft1_nxt;
  part_t         div_remd_nxt;
  part_t         div_quot_nxt;
  adder_t        sum;
  part_t         reg0;
  part_t         reg1;
  logic          sft1;
  xlen_t         mul_res;
  xlen_t         div_res;

  assign is_div = i_req.op[2];

  // Valid needs the request, ready needs the sink
  assign o_valid = wbck & i_valid;
  assign o_ready = wbck & i_ready_out;

  ////////////////////
  // Control

  muldiv_fsm u_fsm (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_ready_out  (i_ready_out),
    .i_op         (i_req.op),
    .i_special    (special),
    .i_exec_last  (exec_last),
    .i_need_corr  (need_corr),
    .o_state      (state),
    .o_exec_enter (exec_enter),
    .o_wbck       (wbck)
  );

  muldiv_exec_cnt u_exec_cnt (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_start     (exec_enter),
    .i_exec      (state == ST_EXEC),
    .i_is_div    (is_div),
    .o_exec_last (exec_last)
  );

  ////////////////////
  // Datapaths

  // Product high in reg0, low in reg1
  booth_mul_dpath u_mul (
    .i_state     (state),
    .i_exec_last (exec_last),
    .i_op        (i_req.op),
    .i_rs1       (i_req.rs1),
    .i_rs2       (i_req.rs2),
    .i_hi        (reg0),
    .i_lo        (reg1),
    .i_sft1      (sft1),
    .i_sum       (sum),
    .o_adder_req (mul_req),
    .o_hi_nxt    (mul_hi_nxt),
    .o_lo_nxt    (mul_lo_nxt),
    .o_sft1_nxt  (mul_sft1_nxt),
    .o_mul_res   (mul_res)
  );

  // Remainder in reg0, quotient in reg1
  nrdiv_dpath u_div (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_state     (state),
    .i_exec_last (exec_last),
    .i_op        (i_req.op),
    .i_rs1       (i_req.rs1),
    .i_rs2       (i_req.rs2),
    .i_remd      (reg0),
    .i_quot      (reg1),
    .i_sum       (sum),
    .o_adder_req (div_req),
    .o_remd_nxt  (div_remd_nxt),
    .o_quot_nxt  (div_quot_nxt),
    .o_need_corr (need_corr),
    .o_div_res   (div_res)
  );

  muldiv_share_dpath u_share (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_is_div       (is_div),
    .i_mul_req      (mul_req),
    .i_div_req      (div_req),
    .i_mul_hi_nxt   (mul_hi_nxt),
    .i_mul_lo_nxt   (mul_lo_nxt),
    .i_div_remd_nxt (div_remd_nxt),
    .i_div_quot_nxt (div_quot_nxt),
    .i_mul_sft1_nxt (mul_sft1_nxt),
    .i_state        (state),
    .i_exec_last    (exec_last),
    .i_ready_out    (i_ready_out),
    .o_sum          (sum),
    .o_reg0         (reg0),
    .o_reg1         (reg1),
    .o_sft1         (sft1)
  );

  muldiv_result_sel u_result_sel (
    .i_req     (i_req),
    .i_mul_res (mul_res),
    .i_div_res (div_res),
    .o_special (special),
    .o_result  (o_result)
  );

endmodule

//--- hdl/muldiv_result_sel.sv
/*
  Special cases and result select
*/
module muldiv_result_sel (
  input  muldiv_pkg::muldiv_req_t i_req,
  input  muldiv_pkg::xlen_t       i_mul_res,
  input  muldiv_pkg::xlen_t       i_div_res,
  output logic                    o_special,
  output muldiv_pkg::xlen_t       o_result
);
  import muldiv_pkg::*;

  logic  is_div;
  logic  is_quot;
  logic  div_by_0;
  logic  div_ovf;
  xlen_t min_int;
  xlen_t special_res;

  assign is_div  = i_req.op[2];
  assign is_quot = (i_req.op == OP_DIV) | (i_req.op == OP_DIVU);
  assign min_int = {1'b1, {(XLEN-1){1'b0}}};

  assign div_by_0 = (i_req.rs2 == '0);
  // Most negative over -1, signed ops only
  assign div_ovf  = ((i_req.op == OP_DIV) | (i_req.op == OP_REM))
                  & (&i_req.rs2) & (i_req.rs1 == min_int);

  assign o_special = is_div & (div_by_0 | div_ovf);

  // By zero gives all ones and the dividend
  // Overflow gives the most negative value and zero
  assign special_res = div_by_0 ? (is_quot ? '1 : i_req.rs1)
                                : (is_quot ? min_int : '0);

  assign o_result = o_special ? special_res
                  : is_div    ? i_div_res
                  :             i_mul_res;

endmodule

//--- hdl/muldiv_share_dpath.sv
/*
  Shared adder and partial registers
*/
module muldiv_share_dpath (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_is_div,
  input  muldiv_pkg::adder_req_t    i_mul_req,
  input  muldiv_pkg::adder_req_t    i_div_req,
  input  muldiv_pkg::part_t         i_mul_hi_nxt,
  input  muldiv_pkg::part_t         i_mul_lo_nxt,
  input  muldiv_pkg::part_t         i_div_remd_nxt,
  input  muldiv_pkg::part_t         i_div_quot_nxt,
  input  logic                      i_mul_sft1_nxt,
  input  muldiv_pkg::muldiv_state_e i_state,
  input  logic                      i_exec_last,
  input  logic                      i_ready_out,
  output muldiv_pkg::adder_t        o_sum,
  output muldiv_pkg::part_t         o_reg0,
  output muldiv_pkg::part_t         o_reg1,
  output logic                      o_sft1
);
  import muldiv_pkg::*;

  adder_req_t req;
  logic       exec_ld;
  logic       reg0_en;
  logic       reg1_en;

  assign req   = i_is_div ? i_div_req : i_mul_req;
  assign o_sum = req.sub ? (req.op1 - req.op2) : (req.op1 + req.op2);

  // Idle and execute steps write both registers
  // Last multiply step holds them for the write-back
  assign exec_ld = (i_state == ST_IDLE)
                 | ((i_state == ST_EXEC) & (~i_exec_last | i_is_div));

  // Remainder fix lands on the write-back handshake
  assign reg0_en = exec_ld | (i_is_div & (i_state == ST_REMD_CORR) & i_ready_out);
  assign reg1_en = exec_ld | (i_is_div & (i_state == ST_QUOT_CORR));

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_reg0 <= '0;
      o_reg1 <= '0;
      o_sft1 <= 1'b0;
    end else begin
      if (reg0_en) begin
        o_reg0 <= i_is_div ? i_div_remd_nxt : i_mul_hi_nxt;
      end
      if (reg1_en) begin
        o_reg1 <= i_is_div ? i_div_quot_nxt : i_mul_lo_nxt;
      end
      // Booth carry bit only for multiply
      if (reg1_en && !i_is_div) begin
        o_sft1 <= i_mul_sft1_nxt;
      end
    end
  end

endmodule

//--- hdl/nrdiv_dpath.sv
/*
  Non-restoring divide step
*/
module nrdiv_dpath (
  input  logic                      clk,
  input  logic                      i_reset,
  input  muldiv_pkg::muldiv_state_e i_state,
  input  logic                      i_exec_last,
  input  muldiv_pkg::muldiv_op_e    i_op,
  input  muldiv_pkg::xlen_t         i_rs1,
  input  muldiv_pkg::xlen_t         i_rs2,
  input  muldiv_pkg::part_t         i_remd,
  input  muldiv_pkg::part_t         i_quot,
  input  muldiv_pkg::adder_t        i_sum,
  output muldiv_pkg::adder_req_t    o_adder_req,
  output muldiv_pkg::part_t         o_remd_nxt,
  output muldiv_pkg::part_t         o_quot_nxt,
  output logic                      o_need_corr,
  output muldiv_pkg::xlen_t         o_div_res
);
  import muldiv_pkg::*;

  logic            is_idle;
  logic            is_exec;
  logic            is_chck;
  logic            is_corr;
  logic            rs1_sign;
  logic            rs2_sign;
  logic [PART_W:0] divisor;
  logic [PART_W:0] sum34;
  logic [PART_W:0] add_op1;
  logic [PART_W:0] add_op2;
  logic            add_sub;
  logic            quot_0;
  logic            prev_quot;
  logic            cur_quot;
  part_t           low_part;
  logic            remd_sft1_q;
  logic            remd_is_0;
  logic            remd_is_divs;
  logic            remd_is_neg_divs;
  logic            remd_inc_quot_dec;
  part_t           div_remd;

  assign is_idle = (i_state == ST_IDLE);
  assign is_exec = (i_state == ST_EXEC);
  assign is_chck = (i_state == ST_REMD_CHCK);
  assign is_corr = (i_state == ST_QUOT_CORR) | (i_state == ST_REMD_CORR);

  assign rs1_sign = (i_op != OP_DIVU) & (i_op != OP_REMU) & i_rs1[XLEN-1];
  assign rs2_sign = (i_op != OP_DIVU) & (i_op != OP_REMU) & i_rs2[XLEN-1];
  assign divisor  = {rs2_sign, rs2_sign, i_rs2};

  // Divide only needs the low 34 sum bits
  assign sum34 = i_sum[PART_W:0];

  ////////////////////
  // Execute step

  // First quotient digit is -1 when the signs differ
  assign quot_0    = ~(rs1_sign ^ rs2_sign);
  assign prev_quot = is_idle ? quot_0 : i_quot[0];
  assign cur_quot  = ~(sum34[PART_W] ^ divisor[PART_W]);

  // Dividend low half with the first digit shifted in
  assign low_part = is_idle ? {i_rs1, quot_0} : i_quot;

  // Adder MSB does not fit the 33-bit remainder register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      remd_sft1_q <= 1'b0;
    end else if (is_idle || is_exec) begin
      remd_sft1_q <= sum34[PART_W-1];
    end
  end

  ////////////////////
  // Check and correction

  assign remd_is_0        = (i_remd == '0);
  assign remd_is_divs     = (i_remd == divisor[PART_W-1:0]);
  // Check cycle adds the divisor
  assign remd_is_neg_divs = (sum34 == '0);

  // Wrong remainder sign, or remainder of plus or minus the divisor
  assign o_need_corr = is_chck & (((i_remd[PART_W-1] ^ rs1_sign) & ~remd_is_0)
                                  | remd_is_neg_divs | remd_is_divs);

  assign remd_inc_quot_dec = i_remd[PART_W-1] ^ divisor[PART_W];

  always_comb begin
    add_op1 = {i_remd[PART_W-1], i_remd};
    add_op2 = divisor;
    case (i_state)
      ST_IDLE, ST_EXEC: begin
        // Add or subtract by the previous digit
        add_op1 = is_idle ? {(PART_W+1){rs1_sign}} : {remd_sft1_q, i_remd};
        add_sub = prev_quot;
      end
      ST_QUOT_CORR: begin
        add_op1 = {i_quot[PART_W-1], i_quot};
        add_op2 = (PART_W+1)'(1);
        add_sub = remd_inc_quot_dec;
      end
      ST_REMD_CORR: begin
        add_sub = ~remd_inc_quot_dec;
      end
      default: begin
        // Remainder plus divisor
        add_sub = 1'b0;
      end
    endcase
  end

  assign o_adder_req = '{op1: {add_op1[PART_W], add_op1},
                         op2: {add_op2[PART_W], add_op2},
                         sub: add_sub};

  // Last step keeps the remainder unshifted
  assign o_remd_nxt = (is_corr | i_exec_last) ? sum34[PART_W-1:0]
                                              : {sum34[PART_W-2:0], low_part[PART_W-1]};

  // Last quotient digit is always one
  assign o_quot_nxt = is_corr     ? sum34[PART_W-1:0]
                    : i_exec_last ? {i_quot[XLEN-1:0], 1'b1}
                    :               {low_part[XLEN-1:0], cur_quot};

  // Corrected remainder comes straight off the adder
  assign div_remd  = is_chck ? i_remd : sum34[PART_W-1:0];
  assign o_div_res = ((i_op == OP_DIV) || (i_op == OP_DIVU)) ? i_quot[XLEN-1:0]
                                                             : div_remd[XLEN-1:0];

endmodule

//--- hdl/booth_mul_dpath.sv
/*
  Radix-4 Booth multiply step
*/
module booth_mul_dpath (
  input  muldiv_pkg::muldiv_state_e i_state,
  input  logic                      i_exec_last,
  input  muldiv_pkg::muldiv_op_e    i_op,
  input  muldiv_pkg::xlen_t         i_rs1,
  input  muldiv_pkg::xlen_t         i_rs2,
  input  muldiv_pkg::part_t         i_hi,
  input  muldiv_pkg::part_t         i_lo,
  input  logic                      i_sft1,
  input  muldiv_pkg::adder_t        i_sum,
  output muldiv_pkg::adder_req_t    o_adder_req,
  output muldiv_pkg::part_t         o_hi_nxt,
  output muldiv_pkg::part_t         o_lo_nxt,
  output logic                      o_sft1_nxt,
  output muldiv_pkg::xlen_t         o_mul_res
);
  import muldiv_pkg::*;

  logic       is_idle;
  logic       rs1_sign;
  logic       rs2_sign;
  logic [2:0] booth_code;
  logic       sel_zero;
  logic       sel_two;
  adder_t     add_op1;
  adder_t     add_op2;

  assign is_idle = (i_state == ST_IDLE);

  // Extend to 33 bits by signedness
  assign rs1_sign = (i_op != OP_MULHU) & i_rs1[XLEN-1];
  assign rs2_sign = (i_op != OP_MULHSU) & (i_op != OP_MULHU) & i_rs2[XLEN-1];

  // Lowest digit comes straight from rs1
  // Last digit pads with the multiplier sign
  assign booth_code = is_idle     ? {i_rs1[1:0], 1'b0}
                    : i_exec_last ? {rs1_sign, i_lo[0], i_sft1}
                    :               {i_lo[1:0], i_sft1};

  // 000 and 111 add nothing, 011 and 100 take twice rs2
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);

  assign add_op2 = sel_zero ? '0
                 : sel_two  ? {{2{rs2_sign}}, i_rs2, 1'b0}
                 :            {{3{rs2_sign}}, i_rs2};

  // Partial product starts from zero
  assign add_op1 = is_idle ? '0 : {{2{i_hi[PART_W-1]}}, i_hi};

  // Upper code bit gives the negative digits
  assign o_adder_req = '{op1: add_op1, op2: add_op2, sub: booth_code[2]};

  // Product shifts right two bits per step
  assign o_hi_nxt   = i_sum[ADDER_W-1:2];
  assign o_lo_nxt   = {i_sum[1:0], is_idle ? {rs1_sign, i_rs1[XLEN-1:2]} : i_lo[PART_W-1:2]};
  assign o_sft1_nxt = is_idle ? i_rs1[1] : i_lo[1];

  // Low word sits in the register, high word is the last sum
  assign o_mul_res = (i_op == OP_MUL) ? i_lo[PART_W-1:1] : i_sum[XLEN-1:0];

endmodule

//--- hdl/muldiv_exec_cnt.sv
/*
  Execute step counter
*/
module muldiv_exec_cnt (
  input  logic clk,
  input  logic i_reset,
  input  logic i_start,
  input  logic i_exec,
  input  logic i_is_div,
  output logic o_exec_last
);
  import muldiv_pkg::*;

  cnt_t cnt_q;
  cnt_t cnt_last;

  // 16 Booth steps or 32 divide steps
  assign cnt_last = i_is_div ? cnt_t'(DIV_STEPS) : cnt_t'(MUL_STEPS);

  assign o_exec_last = i_exec & (cnt_q == cnt_last);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      cnt_q <= '0;
    end else if (i_start) begin
      // Idle cycle already did step 0
      cnt_q <= cnt_t'(1);
    end else if (i_exec && !o_exec_last) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

//--- hdl/muldiv_fsm.sv
/*
  Multiply/divide controller
*/
module muldiv_fsm (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic                      i_ready_out,
  input  muldiv_pkg::muldiv_op_e    i_op,
  input  logic                      i_special,
  input  logic                      i_exec_last,
  input  logic                      i_need_corr,
  output muldiv_pkg::muldiv_state_e o_state,
  output logic                      o_exec_enter,
  output logic                      o_wbck
);
  import muldiv_pkg::*;

  muldiv_state_e state_q;
  muldiv_state_e state_d;
  logic          is_div;
  logic          wbck_hsk;

  assign is_div = i_op[2];

  // Result ready to write back
  // Special cases finish in the issue cycle
  assign o_wbck = (i_valid & i_special)
                | ((state_q == ST_EXEC) & i_exec_last & ~is_div)
                | ((state_q == ST_REMD_CHCK) & ~i_need_corr)
                | (state_q == ST_REMD_CORR);

  // Issue and write-back complete together
  assign wbck_hsk = o_wbck & i_valid & i_ready_out;

  // Idle cycle with a real request is step 0
  assign o_exec_enter = (state_q == ST_IDLE) & i_valid & ~i_special;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (o_exec_enter) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        // Divide always goes on to the check
        if (i_exec_last && is_div) begin
          state_d = ST_REMD_CHCK;
        end else if (wbck_hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (i_need_corr) begin
          state_d = ST_QUOT_CORR;
        end else if (wbck_hsk) begin
          state_d = ST_IDLE;
        end
      end
      ST_QUOT_CORR: begin
        state_d = ST_REMD_CORR;
      end
      ST_REMD_CORR: begin
        // Remainder fix is combinational, hold until taken
        if (wbck_hsk) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_state = state_q;

endmodule

//--- hdl/muldiv_pkg.sv
/*
  Multiply/divide shared definitions
*/
package muldiv_pkg;

  // RV32 operand width
  localparam int XLEN      = 32;
  // Partial registers keep one sign bit above XLEN
  localparam int PART_W    = 33;
  // Two more bits for twice the Booth multiplicand
  localparam int ADDER_W   = 35;
  // Last execute counts per class
  localparam int MUL_STEPS = 16;
  localparam int DIV_STEPS = 32;
  localparam int CNT_W     = 6;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [PART_W-1:0]  part_t;
  typedef logic [ADDER_W-1:0] adder_t;
  typedef logic [CNT_W-1:0]   cnt_t;

  // Top code bit set means divide class
  typedef enum logic [2:0] {
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } muldiv_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_REMD_CHCK,
    ST_QUOT_CORR,
    ST_REMD_CORR
  } muldiv_state_e;

  // Issue request from the core
  typedef struct packed {
    muldiv_op_e op;
    xlen_t      rs1;
    xlen_t      rs2;
  } muldiv_req_t;

  // Request to the shared adder
  // Sum is op1 - op2 when sub is set
  typedef struct packed {
    adder_t op1;
    adder_t op2;
    logic   sub;
  } adder_req_t;

endpackage
